// ==== verilog/daq_pkg.sv ====
`default_nettype none

package daq_pkg;

  // ------------------------------------------------------------------------
  // bus and command widths
  // ------------------------------------------------------------------------
  localparam int unsigned data_w = 16;
  localparam int unsigned addr_w = 19;
  localparam int unsigned cmd_w  = 80;

  typedef logic [data_w-1:0] word_t;
  typedef logic [cmd_w-1:0]  cmd_t;
  typedef logic [addr_w-1:0] addr_t;

  // ------------------------------------------------------------------------
  // register map of the external bus
  // ------------------------------------------------------------------------
  localparam addr_t addr_status      = addr_t'(0);
  localparam addr_t addr_cmd_word1   = addr_t'(1);
  localparam addr_t addr_cmd_word2   = addr_t'(2);
  localparam addr_t addr_cmd_word3   = addr_t'(3);
  localparam addr_t addr_cmd_word4   = addr_t'(4);
  localparam addr_t addr_cmd_word5   = addr_t'(5);
  localparam addr_t addr_next_sample = addr_t'(6);
  localparam addr_t addr_reset_time  = addr_t'(7);
  localparam addr_t addr_run_time    = addr_t'(8);
  localparam addr_t addr_time_lo     = addr_t'(9);
  localparam addr_t addr_time_hi     = addr_t'(10);

  // opcodes
  localparam word_t op_generate = word_t'(1);

  // returned for a sample read with nothing queued
  localparam word_t empty_sample = 16'hdead;

  // command layout, word1 sits in the low 16 bits, word5 in the top 16
  // opcode, count, start value, step, start time, low to high
  localparam int unsigned op_lsb    = 0;
  localparam int unsigned count_lsb = 16;
  localparam int unsigned start_lsb = 32;
  localparam int unsigned step_lsb  = 48;
  localparam int unsigned time_lsb  = 64;

endpackage

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned depth     = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     full,
  output logic     almost_full,
  output logic     empty,
  output logic     almost_empty
);

  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  // storage, no reset on the payload
  payload_t mem [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  // requests past the limits are ignored
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // ------------------------------------------------------------------------
  // pointers and occupancy
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // wrap explicitly, depth need not be a power of two
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // first word falls through
  assign head = mem[rd_ptr];

  // flags straight off the counter
  assign empty        = (count == '0);
  assign full         = (count == cnt_w'(depth));
  assign almost_empty = (count < cnt_w'(2));
  assign almost_full  = (count >= cnt_w'(depth - 2));

  // producer and consumer must respect the flags
  a_no_push_full : assert property (@(posedge clk) disable iff (rst) !(push && full));
  a_no_pop_empty : assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

`default_nettype wire

// ==== verilog/ebi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module ebi_bridge (
  input  logic            clk,
  input  logic            rst,
  input  logic            cs,
  input  logic            rd,
  input  logic            wr,
  input  daq_pkg::addr_t  addr,
  input  daq_pkg::word_t  data_in,
  output daq_pkg::word_t  data_out,
  output logic            irq,
  output daq_pkg::cmd_t   cmd_data,
  output logic            cmd_push,
  input  logic            cmd_full,
  input  logic            cmd_almost_full,
  input  logic            cmd_empty,
  input  logic            cmd_almost_empty,
  input  daq_pkg::word_t  sample_head,
  output logic            sample_pop,
  input  logic            sample_full,
  input  logic            sample_almost_full,
  input  logic            sample_empty,
  input  logic            sample_almost_empty,
  output logic [31:0]     global_time
);

  import daq_pkg::*;

  // flags of two freshly reset FIFOs
  localparam word_t status_reset = 16'h3300;

  typedef enum logic [1:0] {
    idle,
    fetch,
    fifo_read
  } state_t;

  state_t state;

  logic  rd_strobe;
  logic  wr_strobe;
  logic  rd_q;
  logic  rd_qq;
  logic  wr_q;
  logic  wr_qq;
  logic  rd_done;
  logic  wr_done;
  word_t cmd_word [5];
  addr_t last_wr_addr;
  word_t status;
  word_t status_seen;
  logic  time_running;
  logic  reset_time;
  logic  run_time;

  // qualified strobes
  assign rd_strobe = cs && rd;
  assign wr_strobe = cs && wr;

  // ------------------------------------------------------------------------
  // falling edge of the strobes marks the end of a transaction
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_q  <= 1'b0;
      rd_qq <= 1'b0;
      wr_q  <= 1'b0;
      wr_qq <= 1'b0;
    end else begin
      rd_q  <= rd_strobe;
      rd_qq <= rd_q;
      wr_q  <= wr_strobe;
      wr_qq <= wr_q;
    end
  end

  assign rd_done = rd_qq && !rd_q;
  assign wr_done = wr_qq && !wr_q;

  // ------------------------------------------------------------------------
  // fetch / fifo_read control
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= idle;
      sample_pop <= 1'b0;
    end else begin
      sample_pop <= 1'b0;
      case (state)
        idle: state <= fetch;
        fetch: begin
          // sample read started, hold the head until it ends
          if (rd_strobe && addr == addr_next_sample) begin
            state <= fifo_read;
          end
        end
        fifo_read: begin
          if (rd_done) begin
            state      <= fetch;
            sample_pop <= !sample_empty;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // command words, latched every cycle the write strobe is up
  always_ff @(posedge clk) begin
    if (wr_strobe && addr >= addr_cmd_word1 && addr <= addr_cmd_word5) begin
      cmd_word[3'(addr - addr_cmd_word1)] <= data_in;
    end
  end

  assign cmd_data = {cmd_word[4], cmd_word[3], cmd_word[2], cmd_word[1], cmd_word[0]};

  // push once the word5 write is over, drop it on a full FIFO
  always_ff @(posedge clk) begin
    if (rst) begin
      last_wr_addr <= addr_status;
      cmd_push     <= 1'b0;
    end else begin
      if (wr_strobe) begin
        last_wr_addr <= addr;
      end
      cmd_push <= wr_done && last_wr_addr == addr_cmd_word5 && !cmd_full;
    end
  end

  // ------------------------------------------------------------------------
  // status, interrupt and readout
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      status      <= status_reset;
      status_seen <= status_reset;
      irq         <= 1'b0;
      data_out    <= '0;
    end else begin
      status <= {cmd_almost_full, cmd_full, cmd_almost_empty, cmd_empty,
                 sample_almost_full, sample_full, sample_empty, sample_almost_empty,
                 8'h00};
      // raised on any change since the host last looked
      irq <= (status != status_seen);
      if (rd_strobe) begin
        case (addr)
          addr_status: begin
            data_out    <= status;
            status_seen <= status;
          end
          addr_next_sample: data_out <= sample_empty ? empty_sample : sample_head;
          addr_time_lo:     data_out <= global_time[15:0];
          addr_time_hi:     data_out <= global_time[31:16];
          default:          data_out <= '0;
        endcase
      end
    end
  end

  // time base
  assign reset_time = wr_strobe && addr == addr_reset_time;
  assign run_time   = wr_strobe && addr == addr_run_time;

  always_ff @(posedge clk) begin
    if (rst) begin
      global_time  <= '0;
      time_running <= 1'b0;
    end else begin
      if (reset_time) begin
        // a reset also stops the count
        global_time  <= '0;
        time_running <= 1'b0;
      end else if (time_running) begin
        global_time <= global_time + 1'b1;
      end
      if (run_time) begin
        time_running <= 1'b1;
      end
    end
  end

  a_push_not_full : assert property (@(posedge clk) disable iff (rst) cmd_push |-> !cmd_full);

endmodule

`default_nettype wire

// ==== verilog/cmd_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer (
  input  logic           clk,
  input  logic           rst,
  input  daq_pkg::cmd_t  cmd_head,
  input  logic           cmd_empty,
  output logic           cmd_pop,
  input  logic [31:0]    global_time,
  output daq_pkg::word_t sample_data,
  output logic           sample_push,
  input  logic           sample_full
);

  import daq_pkg::*;

  typedef enum logic [1:0] {
    idle,
    wait_time,
    emit
  } state_t;

  state_t state;

  // fields of the head command
  word_t head_op;
  word_t head_count;
  word_t head_start;
  word_t head_step;
  word_t head_time;

  // working copy of the accepted command
  word_t cur_value;
  word_t step;
  word_t remaining;
  word_t start_time;

  logic  accept;
  logic  valid_cmd;

  assign head_op    = cmd_head[op_lsb +: data_w];
  assign head_count = cmd_head[count_lsb +: data_w];
  assign head_start = cmd_head[start_lsb +: data_w];
  assign head_step  = cmd_head[step_lsb +: data_w];
  assign head_time  = cmd_head[time_lsb +: data_w];

  // skip a head that is already being popped
  assign accept    = (state == idle) && !cmd_empty && !cmd_pop;
  assign valid_cmd = (head_op == op_generate) && (head_count != '0);

  // ------------------------------------------------------------------------
  // command fetch and series state
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= idle;
      cmd_pop <= 1'b0;
    end else begin
      cmd_pop <= 1'b0;
      case (state)
        idle: begin
          if (accept) begin
            cmd_pop <= 1'b1;
            // unknown opcodes and empty series are just dropped
            if (valid_cmd) begin
              state <= wait_time;
            end
          end
        end
        wait_time: begin
          // start time is checked against the low half only
          if (global_time[15:0] >= start_time) begin
            state <= emit;
          end
        end
        emit: begin
          if (sample_push && remaining == word_t'(1)) begin
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // series registers
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_value  <= head_start;
      step       <= head_step;
      remaining  <= head_count;
      start_time <= head_time;
    end else if (sample_push) begin
      // wraps at 16 bits
      cur_value <= cur_value + step;
      remaining <= remaining - 1'b1;
    end
  end

  // one sample per cycle, stalled while the sample FIFO is full
  assign sample_push = (state == emit) && !sample_full;
  assign sample_data = cur_value;

  // a series never runs past its count
  a_push_within_count : assert property (@(posedge clk) disable iff (rst)
    sample_push |-> remaining != '0);

endmodule

`default_nettype wire

// ==== verilog/daq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module daq_top #(
  parameter int unsigned cmd_depth    = 4,
  parameter int unsigned sample_depth = 8
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           cs,
  input  logic           rd,
  input  logic           wr,
  input  daq_pkg::addr_t addr,
  input  daq_pkg::word_t data_in,
  output daq_pkg::word_t data_out,
  output logic           irq
);

  import daq_pkg::*;

  // bridge to command FIFO
  cmd_t  cmd_data;
  logic  cmd_push;
  cmd_t  cmd_head;
  logic  cmd_pop;
  logic  cmd_full;
  logic  cmd_almost_full;
  logic  cmd_empty;
  logic  cmd_almost_empty;

  // sequencer to sample FIFO
  word_t sample_data;
  logic  sample_push;
  word_t sample_head;
  logic  sample_pop;
  logic  sample_full;
  logic  sample_almost_full;
  logic  sample_empty;
  logic  sample_almost_empty;

  logic [31:0] global_time;

  ebi_bridge i_bridge (
    .clk                 (clk),
    .rst                 (rst),
    .cs                  (cs),
    .rd                  (rd),
    .wr                  (wr),
    .addr                (addr),
    .data_in             (data_in),
    .data_out            (data_out),
    .irq                 (irq),
    .cmd_data            (cmd_data),
    .cmd_push            (cmd_push),
    .cmd_full            (cmd_full),
    .cmd_almost_full     (cmd_almost_full),
    .cmd_empty           (cmd_empty),
    .cmd_almost_empty    (cmd_almost_empty),
    .sample_head         (sample_head),
    .sample_pop          (sample_pop),
    .sample_full         (sample_full),
    .sample_almost_full  (sample_almost_full),
    .sample_empty        (sample_empty),
    .sample_almost_empty (sample_almost_empty),
    .global_time         (global_time)
  );

  // 80-bit commands
  sync_fifo #(
    .payload_t (cmd_t),
    .depth     (cmd_depth)
  ) i_cmd_fifo (
    .clk          (clk),
    .rst          (rst),
    .push         (cmd_push),
    .push_data    (cmd_data),
    .pop          (cmd_pop),
    .head         (cmd_head),
    .full         (cmd_full),
    .almost_full  (cmd_almost_full),
    .empty        (cmd_empty),
    .almost_empty (cmd_almost_empty)
  );

  // 16-bit samples
  sync_fifo #(
    .payload_t (word_t),
    .depth     (sample_depth)
  ) i_sample_fifo (
    .clk          (clk),
    .rst          (rst),
    .push         (sample_push),
    .push_data    (sample_data),
    .pop          (sample_pop),
    .head         (sample_head),
    .full         (sample_full),
    .almost_full  (sample_almost_full),
    .empty        (sample_empty),
    .almost_empty (sample_almost_empty)
  );

  cmd_sequencer i_sequencer (
    .clk         (clk),
    .rst         (rst),
    .cmd_head    (cmd_head),
    .cmd_empty   (cmd_empty),
    .cmd_pop     (cmd_pop),
    .global_time (global_time),
    .sample_data (sample_data),
    .sample_push (sample_push),
    .sample_full (sample_full)
  );

endmodule

`default_nettype wire

// ==== include/tb_bus_tasks.svh ====
`ifndef tb_bus_tasks_svh
`define tb_bus_tasks_svh

// ----------------------------------------------------------------------------
// error handling
// ----------------------------------------------------------------------------
task automatic abort_run(input string reason);
  $display("%s", reason);
  $display("Simulation failed");
  $fatal(1, "stopped at first error");
endtask

task automatic check(input string name, input logic [31:0] expected,
                     input logic [31:0] actual);
  if (expected !== actual) begin
    abort_run($sformatf("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expected, actual));
  end
endtask

// ----------------------------------------------------------------------------
// bus cycles
// ----------------------------------------------------------------------------

// strobe held two cycles, then four idle
task automatic bus_write(input addr_t a, input word_t d);
  @(posedge clk);
  cs      <= 1'b1;
  wr      <= 1'b1;
  addr    <= a;
  data_in <= d;
  repeat (2) @(posedge clk);
  cs <= 1'b0;
  wr <= 1'b0;
  repeat (4) @(posedge clk);
endtask

// data_out registered on the edge that sees the strobe
task automatic bus_read(input addr_t a, output word_t d);
  @(posedge clk);
  cs   <= 1'b1;
  rd   <= 1'b1;
  addr <= a;
  @(posedge clk);
  cs <= 1'b0;
  rd <= 1'b0;
  @(negedge clk);
  d = data_out;
  // room for the sample pop after the strobe ends
  repeat (4) @(posedge clk);
endtask

// word1 to word5, push follows the last one
task automatic write_command(input word_t op, input word_t count, input word_t start,
                             input word_t step, input word_t start_time);
  bus_write(addr_cmd_word1, op);
  bus_write(addr_cmd_word2, count);
  bus_write(addr_cmd_word3, start);
  bus_write(addr_cmd_word4, step);
  bus_write(addr_cmd_word5, start_time);
endtask

// ----------------------------------------------------------------------------
// bounded waits
// ----------------------------------------------------------------------------
task automatic wait_status(input word_t mask, input word_t value, input string name);
  word_t status;
  bit    seen;
  int    poll;
  seen = 1'b0;
  for (poll = 0; poll < 50 && !seen; poll++) begin
    bus_read(addr_status, status);
    seen = ((status & mask) == value);
  end
  if (!seen) begin
    abort_run($sformatf("%s: timeout, status never matched 0x%0h under mask 0x%0h",
                        name, value, mask));
  end
endtask

task automatic wait_irq(input logic level, input string name);
  int cycles;
  cycles = 0;
  @(negedge clk);
  while (irq !== level && cycles < 100) begin
    @(negedge clk);
    cycles++;
  end
  if (irq !== level) begin
    abort_run($sformatf("%s: timeout, irq did not reach %0b", name, level));
  end
endtask

`endif

// ==== dv/tb_daq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_daq_top;

  import daq_pkg::*;

  // sample FIFO bits of the status word
  localparam word_t sample_full_bit  = 16'h0400;
  localparam word_t sample_empty_bit = 16'h0200;

  logic   clk;
  logic   rst;
  logic   cs;
  logic   rd;
  logic   wr;
  addr_t  addr;
  word_t  data_in;
  word_t  data_out;
  logic   irq;
  integer seed;

  daq_top i_dut (
    .clk      (clk),
    .rst      (rst),
    .cs       (cs),
    .rd       (rd),
    .wr       (wr),
    .addr     (addr),
    .data_in  (data_in),
    .data_out (data_out),
    .irq      (irq)
  );

  // 4 ns period
  always #2 clk = ~clk;

  `include "tb_bus_tasks.svh"

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  // read n samples, expect start + k * step modulo 2^16
  task automatic read_samples(input string name, input word_t start, input word_t step,
                              input int n);
    word_t value;
    word_t expected;
    int    k;
    for (k = 0; k < n; k++) begin
      expected = word_t'(32'(start) + 32'(k) * 32'(step));
      bus_read(addr_next_sample, value);
      check(name, expected, value);
    end
  endtask

  task automatic test_reset_status();
    word_t value;
    bus_read(addr_status, value);
    // both FIFOs empty and almost empty
    check("test_reset_status", 32'h3300, value);
    @(negedge clk);
    check("test_reset_status irq", 32'd0, irq);
  endtask

  task automatic test_time_base();
    word_t value;
    word_t lo_a;
    word_t lo_b;
    bus_write(addr_reset_time, 16'h0000);
    bus_read(addr_time_lo, value);
    check("test_time_base lo", 32'd0, value);
    bus_read(addr_time_hi, value);
    check("test_time_base hi", 32'd0, value);
    bus_write(addr_run_time, 16'h0000);
    repeat (20) @(posedge clk);
    bus_read(addr_time_lo, lo_a);
    bus_read(addr_time_lo, lo_b);
    check("test_time_base running", 32'd1, 32'(lo_b > lo_a));
    // stops and clears again
    bus_write(addr_reset_time, 16'h0000);
    bus_read(addr_time_lo, value);
    check("test_time_base lo after reset", 32'd0, value);
    bus_read(addr_time_hi, value);
    check("test_time_base hi after reset", 32'd0, value);
  endtask

  task automatic test_generate();
    word_t start;
    word_t step;
    start = word_t'($random(seed));
    step  = word_t'($random(seed));
    write_command(op_generate, 16'd5, start, step, 16'd0);
    wait_status(sample_empty_bit, 16'h0000, "test_generate");
    read_samples("test_generate", start, step, 5);
  endtask

  task automatic test_backpressure();
    word_t start;
    word_t step;
    start = word_t'($random(seed));
    step  = word_t'($random(seed));
    // more samples than the FIFO holds
    write_command(op_generate, 16'd12, start, step, 16'd0);
    wait_status(sample_full_bit, sample_full_bit, "test_backpressure");
    read_samples("test_backpressure", start, step, 12);
  endtask

  task automatic test_empty_read();
    word_t value;
    wait_status(sample_empty_bit, sample_empty_bit, "test_empty_read");
    bus_read(addr_next_sample, value);
    check("test_empty_read", 32'h0000dead, value);
  endtask

  task automatic test_irq();
    word_t start;
    word_t step;
    start = word_t'($random(seed));
    step  = word_t'($random(seed));
    wait_status(16'hffff, 16'h3300, "test_irq idle");
    wait_irq(1'b0, "test_irq idle");
    write_command(op_generate, 16'd3, start, step, 16'd0);
    wait_irq(1'b1, "test_irq raise");
    // cmd FIFO drained, three samples queued
    wait_status(16'hffff, 16'h3000, "test_irq settle");
    wait_irq(1'b0, "test_irq clear");
    read_samples("test_irq", start, step, 3);
  endtask

  // --------------------------------------------------------------------------
  // sequence
  // --------------------------------------------------------------------------
  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    cs      = 1'b0;
    rd      = 1'b0;
    wr      = 1'b0;
    addr    = '0;
    data_in = '0;
    seed    = 38;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_reset_status();
    test_time_base();
    test_generate();
    test_backpressure();
    test_empty_read();
    test_irq();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
verilog/daq_pkg.sv
verilog/sync_fifo.sv
verilog/ebi_bridge.sv
verilog/cmd_sequencer.sv
verilog/daq_top.sv
dv/tb_daq_top.sv

// ==== Bender.yml ====
package:
  name: daq_subsystem

dependencies: {}

sources:
  # design
  - files:
      - verilog/daq_pkg.sv
      - verilog/sync_fifo.sv
      - verilog/ebi_bridge.sv
      - verilog/cmd_sequencer.sv
      - verilog/daq_top.sv

  # testbench
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/tb_daq_top.sv
